/* src/axil_ram_pkg.sv */
package axil_ram_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;

    // Storage geometry, 4 KiB
    localparam int RAM_WORDS      = 1024;
    localparam int WORD_IDX_WIDTH = $clog2(RAM_WORDS);

    // One read in the storage stage plus one in the response buffer
    localparam int MAX_INFLIGHT   = 2;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;
    typedef logic [1:0]                resp_t;
    typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;
    typedef logic [1:0]                inflight_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // IDLE accepts traffic, WRITE_RESP holds B, DRAIN empties the read path,
    // PAUSED holds pause_ack
    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        DRAIN,
        PAUSED
    } ctrl_state_t;

endpackage

/* src/ram_port_if.sv */
`timescale 1ns/1ps

interface ram_port_if import axil_ram_pkg::*; ();

    logic      en;
    logic      we;
    word_idx_t idx;
    data_t     wdata;
    strb_t     wstrb;

    // Read slot tag, travels with the data through the storage stage
    logic      issue_valid;
    resp_t     issue_resp;

    modport ctrl (
        output en, we, idx, wdata, wstrb, issue_valid, issue_resp
    );

    modport storage (
        input en, we, idx, wdata, wstrb, issue_valid, issue_resp
    );

endinterface

/* src/axil_ram_ctrl.sv */
`timescale 1ns/1ps

module axil_ram_ctrl import axil_ram_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,

    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,

    output resp_t      bresp,
    output logic       bvalid,
    input  logic       bready,

    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,

    input  logic       pause_req,
    output logic       pause_ack,

    input  inflight_t  inflight,
    output logic       read_issue,

    ram_port_if.ctrl   mem
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    resp_t       wr_resp;
    resp_t       rd_resp;
    logic        wr_accept;
    logic        rd_accept;

    // OKAY only for word aligned addresses inside the array
    function automatic resp_t decode(input addr_t addr);
        if (addr[$clog2(STRB_WIDTH)-1:0] == '0 &&
            addr < addr_t'(RAM_WORDS * STRB_WIDTH)) begin
            return RESP_OKAY;
        end
        return RESP_DECERR;
    endfunction

    function automatic word_idx_t to_idx(input addr_t addr);
        return addr[$clog2(STRB_WIDTH) +: WORD_IDX_WIDTH];
    endfunction

    assign wr_resp = decode(awaddr);
    assign rd_resp = decode(araddr);

    // Writes win over reads in the same cycle
    assign wr_accept = (state == IDLE) && !pause_req && awvalid && wvalid;
    assign rd_accept = (state == IDLE) && !pause_req && !wr_accept && arvalid &&
                       (inflight < inflight_t'(MAX_INFLIGHT));

    assign awready    = wr_accept;
    assign wready     = wr_accept;
    assign arready    = rd_accept;
    assign read_issue = rd_accept;
    assign bvalid     = (state == WRITE_RESP);
    assign pause_ack  = (state == PAUSED);

    // Memory port, enable dropped for decode errors
    assign mem.en          = (wr_accept && wr_resp == RESP_OKAY) ||
                             (rd_accept && rd_resp == RESP_OKAY);
    assign mem.we          = wr_accept && (wr_resp == RESP_OKAY);
    assign mem.idx         = wr_accept ? to_idx(awaddr) : to_idx(araddr);
    assign mem.wdata       = wdata;
    assign mem.wstrb       = wstrb;
    assign mem.issue_valid = rd_accept;
    assign mem.issue_resp  = rd_resp;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pause_req) begin
                    state_next = DRAIN;
                end else if (wr_accept) begin
                    state_next = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (bready) begin
                    state_next = pause_req ? DRAIN : IDLE;
                end
            end
            DRAIN: begin
                if (!bvalid && inflight == '0) begin
                    state_next = PAUSED;
                end
            end
            PAUSED: begin
                if (!pause_req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_resp;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    // Counter feedback must keep AR closed at the pipeline limit
    assert property (@(posedge clk) disable iff (!arst_n)
        inflight == inflight_t'(MAX_INFLIGHT) |-> !arready);

endmodule

/* src/read_inflight_counter.sv */
`timescale 1ns/1ps

module read_inflight_counter import axil_ram_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      read_issue,
    input  logic      pop,
    output inflight_t inflight
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight <= '0;
        end else begin
            case ({read_issue, pop})
                2'b10:   inflight <= inflight + inflight_t'(1);
                2'b01:   inflight <= inflight - inflight_t'(1);
                // Issue and pop together cancel out
                default: inflight <= inflight;
            endcase
        end
    end

    // Holds only if the controller respects the count it is given
    assert property (@(posedge clk) disable iff (!arst_n)
        inflight <= inflight_t'(MAX_INFLIGHT));

    // A pop always belongs to an earlier issue
    assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> inflight != '0);

endmodule

/* src/ram_storage.sv */
`timescale 1ns/1ps

module ram_storage import axil_ram_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    ram_port_if.storage mem,
    output logic       push,
    output data_t      push_data,
    output resp_t      push_resp
);

    data_t ram [RAM_WORDS];

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (mem.en && mem.we) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (mem.wstrb[b]) begin
                    ram[mem.idx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read stage, decode error slots carry zero data
    always_ff @(posedge clk) begin
        if (mem.issue_valid) begin
            push_data <= (mem.en && !mem.we) ? ram[mem.idx] : '0;
            push_resp <= mem.issue_resp;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push <= 1'b0;
        end else begin
            push <= mem.issue_valid;
        end
    end

endmodule

/* src/read_resp_buffer.sv */
`timescale 1ns/1ps

module read_resp_buffer import axil_ram_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  push,
    input  data_t push_data,
    input  resp_t push_resp,
    output logic  rvalid,
    output data_t rdata,
    output resp_t rresp,
    input  logic  rready,
    output logic  pop
);

    // Extra pointer bit tells full from empty
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    data_t      data_q [2];
    resp_t      resp_q [2];
    logic       full;

    assign full   = (wr_ptr[1] != rd_ptr[1]) && (wr_ptr[0] == rd_ptr[0]);
    assign rvalid = (wr_ptr != rd_ptr);
    assign rdata  = data_q[rd_ptr[0]];
    assign rresp  = resp_q[rd_ptr[0]];
    assign pop    = rvalid && rready;

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[wr_ptr[0]] <= push_data;
            resp_q[wr_ptr[0]] <= push_resp;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) full |-> !push);

endmodule

/* src/axil_ram_top.sv */
`timescale 1ns/1ps

module axil_ram_top import axil_ram_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    input  addr_t      awaddr,
    input  logic [2:0] awprot,
    input  logic       awvalid,
    output logic       awready,

    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,

    output resp_t      bresp,
    output logic       bvalid,
    input  logic       bready,

    input  addr_t      araddr,
    input  logic [2:0] arprot,
    input  logic       arvalid,
    output logic       arready,

    output data_t      rdata,
    output resp_t      rresp,
    output logic       rvalid,
    input  logic       rready,

    input  logic       pause_req,
    output logic       pause_ack
);

    inflight_t inflight;
    logic      read_issue;
    logic      pop;
    logic      push;
    data_t     push_data;
    resp_t     push_resp;

    ram_port_if mem_if ();

    axil_ram_ctrl axil_ram_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .pause_req  (pause_req),
        .pause_ack  (pause_ack),
        .inflight   (inflight),
        .read_issue (read_issue),
        .mem        (mem_if.ctrl)
    );

    read_inflight_counter read_inflight_counter_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .read_issue (read_issue),
        .pop        (pop),
        .inflight   (inflight)
    );

    ram_storage ram_storage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem       (mem_if.storage),
        .push      (push),
        .push_data (push_data),
        .push_resp (push_resp)
    );

    read_resp_buffer read_resp_buffer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (push_data),
        .push_resp (push_resp),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rready    (rready),
        .pop       (pop)
    );

endmodule

/* test/axil_ram_tb.sv */
`timescale 1ns/1ps

module axil_ram_tb import axil_ram_pkg::*; ();

    localparam logic [31:0] SEED    = 32'he3d1_73fe;
    localparam int          TIMEOUT = 200;

    logic       clk;
    logic       arst_n;
    addr_t      awaddr;
    logic [2:0] awprot;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    resp_t      bresp;
    logic       bvalid;
    logic       bready;
    addr_t      araddr;
    logic [2:0] arprot;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    resp_t      rresp;
    logic       rvalid;
    logic       rready;
    logic       pause_req;
    logic       pause_ack;

    // Byte-wide model of the 4 KiB array
    logic [7:0]  ref_mem [4096];
    resp_t       exp_bresp [$];
    resp_t       exp_rresp [$];
    data_t       exp_rdata [$];
    addr_t       addr_list [$];
    logic [31:0] rng;
    logic [31:0] rr_state;
    logic        stall_reads;
    logic        bvalid_prev;
    logic        rvalid_prev;
    resp_t       mon_resp;
    data_t       mon_data;
    int          errors;
    int          timeouts;
    int          ar_count;
    int          r_count;
    int          b_count;
    int          max_outstanding;

    axil_ram_top axil_ram_top_i (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Expected response and data for one access
    // The model only takes OKAY writes
    function automatic void ref_access(input logic is_write, input addr_t addr, input data_t data,
                                       input strb_t strb, output resp_t resp, output data_t rd);
        logic       okay;
        logic [11:0] byte_addr;
        okay = (addr[1:0] == 2'b00) && (addr < 32'd4096);
        resp = okay ? 2'b00 : 2'b11;
        rd   = '0;
        if (okay) begin
            for (int b = 0; b < 4; b++) begin
                byte_addr = {addr[11:2], 2'(b)};
                if (is_write && strb[b]) begin
                    ref_mem[byte_addr] = data[b*8 +: 8];
                end
                rd[b*8 +: 8] = ref_mem[byte_addr];
            end
        end
    endfunction

    task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
        resp_t er;
        data_t ed;
        int    n;
        int    b_seen;
        ref_access(1'b1, addr, data, strb, er, ed);
        exp_bresp.push_back(er);
        b_seen  = b_count;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(awready && wready) && n < TIMEOUT);
        if (!(awready && wready)) begin
            timeouts++;
            $display("Write to %h was not accepted within %0d cycles", addr, TIMEOUT);
        end
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (b_count == b_seen && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (b_count == b_seen) begin
            timeouts++;
            $display("No write response for %h within %0d cycles", addr, TIMEOUT);
        end
        @(posedge clk);
        #2;
    endtask

    // Issues the read and leaves R to the monitor
    task automatic issue_read(input addr_t addr);
        resp_t er;
        data_t ed;
        int    n;
        ref_access(1'b0, addr, '0, '0, er, ed);
        exp_rresp.push_back(er);
        exp_rdata.push_back(ed);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!arready && n < TIMEOUT);
        if (!arready) begin
            timeouts++;
            $display("Read of %h was not accepted within %0d cycles", addr, TIMEOUT);
        end
        @(posedge clk);
        #2;
        arvalid = 1'b0;
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (exp_rresp.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_rresp.size() != 0) begin
            timeouts++;
            $display("%0d read responses still missing after %0d cycles",
                     exp_rresp.size(), TIMEOUT);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic check_quiet(input string when);
        assert (!awready && !wready && !arready && !bvalid && !rvalid && !pause_ack) else begin
            errors++;
            $display("Handshake outputs not all low %s at %0t", when, $time);
        end
    endtask

    task automatic random_op();
        logic [31:0] r;
        r = next_rand();
        if (r[28]) begin
            write_word({20'h0, r[11:2], 2'b00}, next_rand(), strb_t'(r[15:12]));
        end else begin
            issue_read({20'h0, r[11:2], 2'b00});
        end
    endtask

    // bready stalls at random throughout the run
    always @(posedge clk) begin
        #2;
        rr_state = xorshift(rr_state);
        bready   = (rr_state[4:3] != 2'd0);
        // rready stalls only during the read burst
        if (stall_reads) begin
            rready = (rr_state[2:0] == 3'd0);
        end else begin
            rready = 1'b1;
        end
    end

    // Sampled half a cycle before the edge that completes a transfer
    always @(negedge clk) begin
        if (arst_n) begin
            if (bvalid && bready) begin
                b_count++;
                if (exp_bresp.size() == 0) begin
                    errors++;
                    $display("Write response at %0t with no write outstanding", $time);
                end else begin
                    mon_resp = exp_bresp.pop_front();
                    assert (bresp === mon_resp) else begin
                        errors++;
                        $display("FAILED %0t bresp got %h expected %h", $time, bresp, mon_resp);
                    end
                end
            end
            if (arvalid && arready) begin
                ar_count++;
            end
            if (rvalid && rready) begin
                r_count++;
                if (exp_rresp.size() == 0) begin
                    errors++;
                    $display("Read response at %0t with no read outstanding", $time);
                end else begin
                    mon_resp = exp_rresp.pop_front();
                    mon_data = exp_rdata.pop_front();
                    assert (rresp === mon_resp) else begin
                        errors++;
                        $display("FAILED %0t rresp got %h expected %h", $time, rresp, mon_resp);
                    end
                    assert (rdata === mon_data) else begin
                        errors++;
                        $display("FAILED %0t rdata got %h expected %h", $time, rdata, mon_data);
                    end
                end
            end
            assert (ar_count - r_count <= 2) else begin
                errors++;
                $display("More than two reads accepted without a response at %0t", $time);
            end
            if (ar_count - r_count > max_outstanding) begin
                max_outstanding = ar_count - r_count;
            end
            if (pause_req) begin
                assert (!awready && !wready && !arready) else begin
                    errors++;
                    $display("A ready output is high during a pause request at %0t", $time);
                end
            end
            if (pause_ack) begin
                assert (!(bvalid && !bvalid_prev) && !(rvalid && !rvalid_prev)) else begin
                    errors++;
                    $display("A new response appeared while paused at %0t", $time);
                end
            end
        end
        bvalid_prev = bvalid;
        rvalid_prev = rvalid;
    end

    initial begin
        logic [31:0] r;
        int          n;
        clk = 1'b0;
        arst_n = 1'b0;
        awaddr = '0;
        awprot = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arprot = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        pause_req = 1'b0;
        rng = SEED;
        rr_state = ~SEED;
        stall_reads = 1'b0;
        bvalid_prev = 1'b0;
        rvalid_prev = 1'b0;
        errors = 0;
        timeouts = 0;
        ar_count = 0;
        r_count = 0;
        b_count = 0;
        max_outstanding = 0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = 8'h00;
        end

        repeat (8) @(posedge clk);
        check_quiet("during reset");
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_quiet("after reset");
        @(posedge clk);
        #2;

        // Full sweep with each word holding its own address
        for (int w = 0; w < 1024; w++) begin
            write_word(addr_t'(w * 4), data_t'(w * 4), 4'hf);
        end
        for (int w = 0; w < 1024; w++) begin
            issue_read(addr_t'(w * 4));
        end
        wait_reads_done();

        // Partial strobes
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            addr_list.push_back({20'h0, r[11:2], 2'b00});
            write_word({20'h0, r[11:2], 2'b00}, next_rand(), strb_t'(r[15:12]));
        end
        while (addr_list.size() != 0) begin
            issue_read(addr_list.pop_front());
        end
        wait_reads_done();

        // Unaligned and out of range accesses followed by the aliased word
        for (int k = 0; k < 12; k++) begin
            r = next_rand();
            if (k < 6) begin
                r = {20'h0, r[11:2], 2'(k % 3 + 1)};
            end else if (k < 11) begin
                r = {19'h0, 1'b1, r[11:0]};
            end else begin
                r = 32'h0000_2000;
            end
            write_word(r, next_rand(), 4'hf);
            issue_read(r);
            issue_read({20'h0, r[11:2], 2'b00});
        end
        wait_reads_done();

        // Back-to-back reads under rready stalls
        max_outstanding = 0;
        stall_reads = 1'b1;
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            issue_read({20'h0, r[11:2], 2'b00});
        end
        stall_reads = 1'b0;
        wait_reads_done();
        assert (max_outstanding == 2) else begin
            errors++;
            $display("Read pipeline never held two reads, peak was %0d", max_outstanding);
        end

        // Pauses in the middle of random traffic
        fork
            begin
                for (int i = 0; i < 80; i++) begin
                    random_op();
                end
            end
            begin
                for (int p = 0; p < 3; p++) begin
                    repeat (12) @(posedge clk);
                    #2;
                    pause_req = 1'b1;
                    n = 0;
                    while (!pause_ack && n < TIMEOUT) begin
                        @(negedge clk);
                        n++;
                    end
                    if (!pause_ack) begin
                        timeouts++;
                        $display("pause_ack did not rise within %0d cycles", TIMEOUT);
                    end
                    repeat (5) @(posedge clk);
                    #2;
                    pause_req = 1'b0;
                    n = 0;
                    while (pause_ack && n < TIMEOUT) begin
                        @(negedge clk);
                        n++;
                    end
                    if (pause_ack) begin
                        timeouts++;
                        $display("pause_ack stayed high after pause_req fell");
                    end
                end
            end
        join
        wait_reads_done();
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            issue_read({20'h0, r[11:2], 2'b00});
        end
        wait_reads_done();

        if (exp_bresp.size() != 0 || exp_rresp.size() != 0) begin
            errors++;
            $display("Responses missing at the end of the run");
        end
        $display("Done: %0d errors, %0d timeouts, %0d writes, %0d reads",
                 errors, timeouts, b_count, r_count);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/axil_ram_pkg.sv
src/ram_port_if.sv
src/axil_ram_ctrl.sv
src/read_inflight_counter.sv
src/ram_storage.sv
src/read_resp_buffer.sv
src/axil_ram_top.sv
test/axil_ram_tb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run, the verdict comes from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module axil_ram_tb \
    -f verilog.f -o axil_ram_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/axil_ram_sim > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
